// ==== src/csr_pkg.sv ====
package csr_pkg;

	localparam int xlen      = 32;
	localparam int time_w    = 64;
	localparam int medeleg_w = 16;
	localparam int mideleg_w = 12;

	typedef logic [11:0]     csr_addr_t;
	typedef logic [xlen-1:0] word_t;

	// machine level
	localparam csr_addr_t addr_mstatus  = 12'h300;
	localparam csr_addr_t addr_medeleg  = 12'h302;
	localparam csr_addr_t addr_mideleg  = 12'h303;
	localparam csr_addr_t addr_mie      = 12'h304;
	localparam csr_addr_t addr_mtvec    = 12'h305;
	localparam csr_addr_t addr_mscratch = 12'h340;
	localparam csr_addr_t addr_mepc     = 12'h341;
	localparam csr_addr_t addr_mcause   = 12'h342;
	localparam csr_addr_t addr_mip      = 12'h344;
	localparam csr_addr_t addr_mtimecmp = 12'hbbf;	// custom slot

	// supervisor level
	localparam csr_addr_t addr_sstatus  = 12'h100;
	localparam csr_addr_t addr_sie      = 12'h104;
	localparam csr_addr_t addr_stvec    = 12'h105;
	localparam csr_addr_t addr_sscratch = 12'h140;
	localparam csr_addr_t addr_sepc     = 12'h141;
	localparam csr_addr_t addr_scause   = 12'h142;
	localparam csr_addr_t addr_sip      = 12'h144;
	localparam csr_addr_t addr_stimecmp = 12'h5c0;	// custom slot

	// read-only counter
	localparam csr_addr_t addr_time     = 12'hc01;
	localparam csr_addr_t addr_timeh    = 12'hc81;

	// common cause codes, interrupt flag kept separately
	localparam logic [30:0] exc_illegal  = 31'd2;
	localparam logic [30:0] exc_ecall_u  = 31'd8;
	localparam logic [30:0] exc_ecall_s  = 31'd9;
	localparam logic [30:0] exc_ecall_m  = 31'd11;
	localparam logic [30:0] irq_s_timer  = 31'd5;
	localparam logic [30:0] irq_m_timer  = 31'd7;

	typedef enum logic [1:0] {
		mode_u   = 2'b00,
		mode_s   = 2'b01,
		mode_rsv = 2'b10,
		mode_m   = 2'b11
	} mode_t;

	typedef struct packed {
		logic        interrupt;
		logic [30:0] code;
	} cause_t;

	// mstatus layout of a written word
	typedef struct packed {
		logic [31:23] pad23;
		logic         tsr;
		logic [21:13] pad13;
		mode_t        mpp;
		logic [10:9]  pad9;
		logic         spp;
		logic         mpie;
		logic         pad6;
		logic         spie;
		logic         pad4;
		logic         mie;
		logic         pad2;
		logic         sie;
		logic         pad0;
	} status_view_t;

	// mie/mip layout, same bit positions for enables and pendings
	typedef struct packed {
		logic [31:12] pad12;
		logic         meie;
		logic         pad10;
		logic         seie;
		logic         pad8;
		logic         mtie;
		logic         pad6;
		logic         stie;
		logic [4:0]   pad0;
	} enable_view_t;

	typedef union packed {
		word_t        word;
		status_view_t status;
		enable_view_t enable;
	} csr_wdata_u;

	typedef struct packed {
		logic mstatus;
		logic mie;
		logic mtvec;
		logic mscratch;
		logic mepc;
		logic mcause;
		logic medeleg;
		logic mideleg;
		logic mtimecmp;
		logic sstatus;
		logic sie;
		logic stvec;
		logic sscratch;
		logic sepc;
		logic scause;
		logic stimecmp;
	} csr_wsel_t;

	typedef struct packed {
		logic  sie;
		logic  mie;
		logic  spie;
		logic  mpie;
		logic  spp;
		mode_t mpp;
		logic  tsr;
	} status_t;

	typedef struct packed {
		logic stie;
		logic mtie;
		logic seie;
		logic meie;
	} enable_t;

	typedef struct packed {
		logic [medeleg_w-1:0] medeleg;
		logic [mideleg_w-1:0] mideleg;
	} deleg_t;

endpackage

// ==== src/csr_addr_decode.sv ====
`timescale 1ns/1ps

module csr_addr_decode
(
	input  logic               csr_we,
	input  csr_pkg::csr_addr_t csr_address_wb,
	input  logic               exception_pending,
	output csr_pkg::csr_wsel_t wsel
);
	import csr_pkg::*;

	// write-back is dropped while a trap or xret is in flight
	always_comb
	begin
		wsel = '0;
		if (csr_we && !exception_pending)
		begin
			case (csr_address_wb)
				addr_mstatus:  wsel.mstatus  = 1'b1;
				addr_mie:      wsel.mie      = 1'b1;
				addr_mtvec:    wsel.mtvec    = 1'b1;
				addr_mscratch: wsel.mscratch = 1'b1;
				addr_mepc:     wsel.mepc     = 1'b1;
				addr_mcause:   wsel.mcause   = 1'b1;
				addr_medeleg:  wsel.medeleg  = 1'b1;
				addr_mideleg:  wsel.mideleg  = 1'b1;
				addr_mtimecmp: wsel.mtimecmp = 1'b1;
				addr_sstatus:  wsel.sstatus  = 1'b1;
				addr_sie:      wsel.sie      = 1'b1;
				addr_stvec:    wsel.stvec    = 1'b1;
				addr_sscratch: wsel.sscratch = 1'b1;
				addr_sepc:     wsel.sepc     = 1'b1;
				addr_scause:   wsel.scause   = 1'b1;
				addr_stimecmp: wsel.stimecmp = 1'b1;
				default:       wsel          = '0;	// read-only or unknown
			endcase
		end
	end

	// two registers updated by one write would corrupt state downstream
	wsel_onehot: assert final ($onehot0(wsel))
		else $error("csr write selects not one-hot: %b", wsel);

endmodule

// ==== src/csr_trap_ctrl.sv ====
`timescale 1ns/1ps

module csr_trap_ctrl
(
	input  logic                clk,
	input  logic                nrst,
	input  csr_pkg::csr_wsel_t  wsel,
	input  csr_pkg::csr_wdata_u csr_wb,
	input  logic                exception_pending,
	input  csr_pkg::cause_t     cause,
	input  csr_pkg::word_t      pc_exc,
	input  logic                m_ret,
	input  logic                s_ret,
	input  csr_pkg::deleg_t     deleg,
	output csr_pkg::mode_t      current_mode,
	output csr_pkg::status_t    status,
	output csr_pkg::word_t      mepc,
	output csr_pkg::word_t      sepc,
	output csr_pkg::cause_t     mcause,
	output csr_pkg::cause_t     scause,
	output logic                illegal_ret
);
	import csr_pkg::*;

	mode_t next_mode;
	logic  delegated;
	logic  trap;
	logic  trap_to_m;
	logic  trap_to_s;
	logic  mret_ok;
	logic  sret_ok;
	word_t pc_aligned;

	// delegation bit picked by the cause code, out of range means no delegation
	always_comb
	begin
		delegated = 1'b0;
		if (cause.interrupt)
		begin
			if (cause.code < mideleg_w)
				delegated = deleg.mideleg[cause.code[3:0]];
		end
		else if (cause.code < medeleg_w)
		begin
			delegated = deleg.medeleg[cause.code[3:0]];
		end
	end

	// xret arrives together with exception_pending
	assign trap    = exception_pending && !m_ret && !s_ret;
	assign mret_ok = exception_pending && m_ret && current_mode == mode_m;
	assign sret_ok = exception_pending && s_ret && !m_ret && current_mode != mode_u;

	assign illegal_ret = exception_pending &&
		((m_ret && current_mode != mode_m) || (s_ret && current_mode == mode_u));

	always_comb
	begin
		next_mode = current_mode;
		if (mret_ok)
			next_mode = status.mpp;
		else if (sret_ok)
			next_mode = status.spp ? mode_s : mode_u;
		else if (trap && current_mode == mode_m && delegated)
			next_mode = mode_s;
	end

	assign trap_to_m  = trap && next_mode == mode_m;
	assign trap_to_s  = trap && next_mode == mode_s;	// also a trap taken in S
	assign pc_aligned = {pc_exc[xlen-1:2], 2'b00};

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= mode_m;
			status       <= status_t'{mpp: mode_m, default: 1'b0};
			mepc         <= '0;
			sepc         <= '0;
			mcause       <= '0;
			scause       <= '0;
		end
		else
		begin
			current_mode <= next_mode;
			if (trap_to_m)
			begin
				mepc        <= pc_aligned;
				mcause      <= cause;
				status.mpie <= status.mie;
				status.mie  <= 1'b0;
				status.mpp  <= current_mode;
			end
			else if (trap_to_s)
			begin
				sepc        <= pc_aligned;
				scause      <= cause;
				status.spie <= status.sie;
				status.sie  <= 1'b0;
				status.spp  <= current_mode[0];
			end
			else if (mret_ok)
			begin
				status.mie  <= status.mpie;
				status.mpie <= 1'b1;
				status.mpp  <= mode_u;
			end
			else if (sret_ok)
			begin
				status.sie  <= status.spie;
				status.spie <= 1'b1;
				status.spp  <= 1'b0;
			end
			else
			begin
				if (wsel.mstatus)
				begin
					status.sie  <= csr_wb.status.sie;
					status.mie  <= csr_wb.status.mie;
					status.spie <= csr_wb.status.spie;
					status.mpie <= csr_wb.status.mpie;
					status.spp  <= csr_wb.status.spp;
					status.tsr  <= csr_wb.status.tsr;
					if (csr_wb.status.mpp != mode_rsv)	// keep a legal mpp
						status.mpp <= csr_wb.status.mpp;
				end
				if (wsel.sstatus)
				begin
					status.sie  <= csr_wb.status.sie;
					status.spie <= csr_wb.status.spie;
					status.spp  <= csr_wb.status.spp;
				end
				if (wsel.mepc)
					mepc <= {csr_wb.word[xlen-1:2], 2'b00};
				if (wsel.sepc)
					sepc <= {csr_wb.word[xlen-1:2], 2'b00};
				if (wsel.mcause)
					mcause <= csr_wb.word;
				if (wsel.scause)
					scause <= csr_wb.word;
			end
		end
	end

	mode_legal: assert property (@(posedge clk) disable iff (!nrst)
		current_mode != mode_rsv);

	// the decode stage issues at most one xret per cycle
	single_ret: assert property (@(posedge clk) disable iff (!nrst)
		!(m_ret && s_ret));

endmodule

// ==== src/csr_config_regs.sv ====
`timescale 1ns/1ps

module csr_config_regs
(
	input  logic                        clk,
	input  logic                        nrst,
	input  csr_pkg::csr_wsel_t          wsel,
	input  csr_pkg::csr_wdata_u         csr_wb,
	output csr_pkg::word_t              tvec_m,
	output csr_pkg::word_t              tvec_s,
	output csr_pkg::word_t              mscratch,
	output csr_pkg::word_t              sscratch,
	output csr_pkg::enable_t            enables,
	output csr_pkg::deleg_t             deleg,
	output logic [csr_pkg::time_w-1:0] mtimecmp,
	output logic [csr_pkg::time_w-1:0] stimecmp
);
	import csr_pkg::*;

	logic [xlen-1:2] mtvec_q;	// direct mode only
	logic [xlen-1:2] stvec_q;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtvec_q  <= '0;
			stvec_q  <= '0;
			mscratch <= '0;
			sscratch <= '0;
			enables  <= '0;
			deleg    <= '0;
			mtimecmp <= '0;
			stimecmp <= '0;
		end
		else
		begin
			if (wsel.mtvec)
				mtvec_q <= csr_wb.word[xlen-1:2];
			if (wsel.stvec)
				stvec_q <= csr_wb.word[xlen-1:2];
			if (wsel.mscratch)
				mscratch <= csr_wb.word;
			if (wsel.sscratch)
				sscratch <= csr_wb.word;
			if (wsel.mie)
			begin
				enables.stie <= csr_wb.enable.stie;
				enables.mtie <= csr_wb.enable.mtie;
				enables.seie <= csr_wb.enable.seie;
				enables.meie <= csr_wb.enable.meie;
			end
			if (wsel.sie)	// sie is the S view of mie
			begin
				enables.stie <= csr_wb.enable.stie;
				enables.seie <= csr_wb.enable.seie;
			end
			if (wsel.medeleg)
				deleg.medeleg <= csr_wb.word[medeleg_w-1:0];
			if (wsel.mideleg)
				deleg.mideleg <= csr_wb.word[mideleg_w-1:0];
			// compare values are written through one 32-bit slot, upper half cleared
			if (wsel.mtimecmp)
				mtimecmp <= time_w'(csr_wb.word);
			if (wsel.stimecmp)
				stimecmp <= time_w'(csr_wb.word);
		end
	end

	assign tvec_m = {mtvec_q, 2'b00};
	assign tvec_s = {stvec_q, 2'b00};

endmodule

// ==== src/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer
(
	input  logic                        clk,
	input  logic                        nrst,
	input  logic [csr_pkg::time_w-1:0] mtimecmp,
	input  logic [csr_pkg::time_w-1:0] stimecmp,
	output logic [csr_pkg::time_w-1:0] mtime,
	output logic                        m_timer,
	output logic                        s_timer
);
	import csr_pkg::*;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtime   <= '0;
			m_timer <= 1'b0;
			s_timer <= 1'b0;
		end
		else
		begin
			mtime   <= mtime + time_w'(1);	// free running, wraps
			m_timer <= (mtime >= mtimecmp);
			s_timer <= (mtime >= stimecmp);
		end
	end

endmodule

// ==== src/csr_read_result.sv ====
`timescale 1ns/1ps

module csr_read_result
(
	input  csr_pkg::csr_addr_t          csr_address_r,
	input  csr_pkg::mode_t              current_mode,
	input  csr_pkg::status_t            status,
	input  csr_pkg::enable_t            enables,
	input  csr_pkg::deleg_t             deleg,
	input  csr_pkg::word_t              tvec_m,
	input  csr_pkg::word_t              tvec_s,
	input  csr_pkg::word_t              mscratch,
	input  csr_pkg::word_t              sscratch,
	input  csr_pkg::word_t              mepc,
	input  csr_pkg::word_t              sepc,
	input  csr_pkg::cause_t             mcause,
	input  csr_pkg::cause_t             scause,
	input  logic [csr_pkg::time_w-1:0] mtime,
	input  logic [csr_pkg::time_w-1:0] mtimecmp,
	input  logic [csr_pkg::time_w-1:0] stimecmp,
	input  logic                        m_timer,
	input  logic                        s_timer,
	input  logic                        m_interrupt,
	input  logic                        s_interrupt,
	input  logic                        m_ret,
	input  logic                        s_ret,
	output csr_pkg::word_t              csr_data,
	output csr_pkg::word_t              epc,
	output logic                        m_eie,
	output logic                        m_tie,
	output logic                        s_eie,
	output logic                        s_tie,
	output logic                        tsr
);
	import csr_pkg::*;

	status_view_t mstatus_w;
	status_view_t sstatus_w;
	enable_view_t mie_w;
	enable_view_t sie_w;
	enable_view_t mip_w;
	enable_view_t sip_w;
	word_t        tvec_cur;

	always_comb
	begin
		mstatus_w      = '0;
		mstatus_w.sie  = status.sie;
		mstatus_w.mie  = status.mie;
		mstatus_w.spie = status.spie;
		mstatus_w.mpie = status.mpie;
		mstatus_w.spp  = status.spp;
		mstatus_w.mpp  = status.mpp;
		mstatus_w.tsr  = status.tsr;
		sstatus_w      = '0;	// S view hides the M fields
		sstatus_w.sie  = status.sie;
		sstatus_w.spie = status.spie;
		sstatus_w.spp  = status.spp;
	end

	always_comb
	begin
		mie_w      = '0;
		mie_w.stie = enables.stie;
		mie_w.mtie = enables.mtie;
		mie_w.seie = enables.seie;
		mie_w.meie = enables.meie;
		sie_w      = '0;
		sie_w.stie = enables.stie;
		sie_w.seie = enables.seie;
		mip_w      = '0;	// pending bits share the enable positions
		mip_w.stie = s_timer;
		mip_w.mtie = m_timer;
		mip_w.seie = s_interrupt;
		mip_w.meie = m_interrupt;
		sip_w      = '0;
		sip_w.stie = s_timer;
		sip_w.seie = s_interrupt;
	end

	always_comb
	begin
		case (csr_address_r)
			addr_mstatus:  csr_data = mstatus_w;
			addr_mie:      csr_data = mie_w;
			addr_mip:      csr_data = mip_w;
			addr_mtvec:    csr_data = tvec_m;
			addr_mscratch: csr_data = mscratch;
			addr_mepc:     csr_data = mepc;
			addr_mcause:   csr_data = mcause;
			addr_medeleg:  csr_data = word_t'(deleg.medeleg);
			addr_mideleg:  csr_data = word_t'(deleg.mideleg);
			addr_mtimecmp: csr_data = mtimecmp[xlen-1:0];
			addr_sstatus:  csr_data = sstatus_w;
			addr_sie:      csr_data = sie_w;
			addr_sip:      csr_data = sip_w;
			addr_stvec:    csr_data = tvec_s;
			addr_sscratch: csr_data = sscratch;
			addr_sepc:     csr_data = sepc;
			addr_scause:   csr_data = scause;
			addr_stimecmp: csr_data = stimecmp[xlen-1:0];
			addr_time:     csr_data = mtime[xlen-1:0];
			addr_timeh:    csr_data = mtime[time_w-1:xlen];
			default:       csr_data = '0;
		endcase
	end

	// trap target follows the mode the core is in now
	assign tvec_cur = (current_mode == mode_m) ? tvec_m : tvec_s;

	always_comb
	begin
		case ({m_ret, s_ret})
			2'b10:   epc = mepc;
			2'b01:   epc = sepc;
			default: epc = tvec_cur;
		endcase
	end

	assign m_eie = enables.meie && status.mie;
	assign m_tie = enables.mtie && status.mie;
	assign s_eie = enables.seie && status.sie;
	assign s_tie = enables.stie && status.sie;
	assign tsr   = status.tsr;

	// front end fetches from word-aligned targets only
	epc_aligned: assert final (epc[1:0] == 2'b00)
		else $error("misaligned epc %h", epc);

endmodule

// ==== src/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile
(
	input  logic               clk,
	input  logic               nrst,
	input  logic               csr_we,
	input  csr_pkg::csr_addr_t csr_address_wb,
	input  csr_pkg::word_t     csr_wb,
	input  csr_pkg::csr_addr_t csr_address_r,
	input  logic               exception_pending,
	input  csr_pkg::cause_t    cause,
	input  csr_pkg::word_t     pc_exc,
	input  logic               m_ret,
	input  logic               s_ret,
	input  logic               m_interrupt,
	input  logic               s_interrupt,
	output csr_pkg::word_t     csr_data,
	output csr_pkg::word_t     epc,
	output csr_pkg::mode_t     current_mode,
	output logic               illegal_ret,
	output logic               m_timer,
	output logic               s_timer,
	output logic               m_eie,
	output logic               m_tie,
	output logic               s_eie,
	output logic               s_tie,
	output logic               tsr
);
	import csr_pkg::*;

	csr_wsel_t           wsel;
	status_t             status;
	enable_t             enables;
	deleg_t              deleg;
	word_t               tvec_m;
	word_t               tvec_s;
	word_t               mscratch;
	word_t               sscratch;
	word_t               mepc;
	word_t               sepc;
	cause_t              mcause;
	cause_t              scause;
	logic [time_w-1:0]   mtime;
	logic [time_w-1:0]   mtimecmp;
	logic [time_w-1:0]   stimecmp;

	csr_addr_decode u_decode (
		.csr_we            (csr_we),
		.csr_address_wb    (csr_address_wb),
		.exception_pending (exception_pending),
		.wsel              (wsel)
	);

	csr_trap_ctrl u_trap (
		.clk               (clk),
		.nrst              (nrst),
		.wsel              (wsel),
		.csr_wb            (csr_wb),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.deleg             (deleg),
		.current_mode      (current_mode),
		.status            (status),
		.mepc              (mepc),
		.sepc              (sepc),
		.mcause            (mcause),
		.scause            (scause),
		.illegal_ret       (illegal_ret)
	);

	csr_config_regs u_config (
		.clk      (clk),
		.nrst     (nrst),
		.wsel     (wsel),
		.csr_wb   (csr_wb),
		.tvec_m   (tvec_m),
		.tvec_s   (tvec_s),
		.mscratch (mscratch),
		.sscratch (sscratch),
		.enables  (enables),
		.deleg    (deleg),
		.mtimecmp (mtimecmp),
		.stimecmp (stimecmp)
	);

	csr_timer u_timer (
		.clk      (clk),
		.nrst     (nrst),
		.mtimecmp (mtimecmp),
		.stimecmp (stimecmp),
		.mtime    (mtime),
		.m_timer  (m_timer),
		.s_timer  (s_timer)
	);

	csr_read_result u_result (
		.csr_address_r (csr_address_r),
		.current_mode  (current_mode),
		.status        (status),
		.enables       (enables),
		.deleg         (deleg),
		.tvec_m        (tvec_m),
		.tvec_s        (tvec_s),
		.mscratch      (mscratch),
		.sscratch      (sscratch),
		.mepc          (mepc),
		.sepc          (sepc),
		.mcause        (mcause),
		.scause        (scause),
		.mtime         (mtime),
		.mtimecmp      (mtimecmp),
		.stimecmp      (stimecmp),
		.m_timer       (m_timer),
		.s_timer       (s_timer),
		.m_interrupt   (m_interrupt),
		.s_interrupt   (s_interrupt),
		.m_ret         (m_ret),
		.s_ret         (s_ret),
		.csr_data      (csr_data),
		.epc           (epc),
		.m_eie         (m_eie),
		.m_tie         (m_tie),
		.s_eie         (s_eie),
		.s_tie         (s_tie),
		.tsr           (tsr)
	);

endmodule

// ==== verification/csr_regfile_tb.sv ====
`timescale 1ns/1ps

module csr_regfile_tb;
	import csr_pkg::*;

	localparam int clk_period  = 20;
	localparam int test_cycles = 300;	// whole sequence, with room to spare
	localparam int margin      = 50;

	logic      clk;
	logic      nrst;
	logic      csr_we;
	csr_addr_t csr_address_wb;
	word_t     csr_wb;
	csr_addr_t csr_address_r;
	logic      exception_pending;
	cause_t    cause;
	word_t     pc_exc;
	logic      m_ret;
	logic      s_ret;
	logic      m_interrupt;
	logic      s_interrupt;
	word_t     csr_data;
	word_t     epc;
	mode_t     current_mode;
	logic      illegal_ret;
	logic      m_timer;
	logic      s_timer;
	logic      m_eie;
	logic      m_tie;
	logic      s_eie;
	logic      s_tie;
	logic      tsr;

	// shadow state, kept in step with the DUT registers
	mode_t       exp_mode;
	mode_t       exp_mpp;
	logic        exp_sie;
	logic        exp_mie;
	logic        exp_spie;
	logic        exp_mpie;
	logic        exp_spp;
	logic        exp_tsr;
	logic        exp_stie;
	logic        exp_mtie;
	logic        exp_seie;
	logic        exp_meie;
	word_t       exp_mtvec;
	word_t       exp_stvec;
	word_t       exp_mepc;
	word_t       exp_sepc;
	cause_t      exp_mcause;
	cause_t      exp_scause;
	logic [15:0] exp_medeleg;
	logic [11:0] exp_mideleg;
	logic [15:0] lfsr;
	logic [63:0] cycles;	// mirrors mtime
	int          failures;

	csr_regfile dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (nrst)
			cycles <= cycles + 64'd1;
	end

	initial
	begin
		#(clk_period * (test_cycles + margin));
		abort_run("watchdog expired, the test sequence did not finish in time");
	end

	task automatic abort_run(input string reason);
		failures++;
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic value_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		abort_run($sformatf("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp));
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		value_ok: assert (got === exp)
			else value_mismatch(name, got, exp);
	endtask

	mode_tracks: assert property (@(posedge clk) disable iff (!nrst) current_mode == exp_mode)
		else value_mismatch("current_mode", $sampled(current_mode), $sampled(exp_mode));

	tie_tracks: assert property (@(posedge clk) disable iff (!nrst)
		m_tie == (exp_mie && exp_mtie))
		else value_mismatch("m_tie", $sampled(m_tie), $sampled(exp_mie && exp_mtie));

	m_eie_tracks: assert property (@(posedge clk) disable iff (!nrst)
		m_eie == (exp_mie && exp_meie))
		else value_mismatch("m_eie", $sampled(m_eie), $sampled(exp_mie && exp_meie));

	s_eie_tracks: assert property (@(posedge clk) disable iff (!nrst)
		s_eie == (exp_sie && exp_seie))
		else value_mismatch("s_eie", $sampled(s_eie), $sampled(exp_sie && exp_seie));

	s_tie_tracks: assert property (@(posedge clk) disable iff (!nrst)
		s_tie == (exp_sie && exp_stie))
		else value_mismatch("s_tie", $sampled(s_tie), $sampled(exp_sie && exp_stie));

	tsr_tracks: assert property (@(posedge clk) disable iff (!nrst) tsr == exp_tsr)
		else value_mismatch("tsr", $sampled(tsr), $sampled(exp_tsr));

	illegal_needs_ret: assert property (@(posedge clk) disable iff (!nrst)
		illegal_ret |-> exception_pending && (m_ret || s_ret))
		else abort_run("illegal_ret went high without an xRET in flight");

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic word_t random_word();
		word_t w;
		w = '0;
		for (int i = 0; i < xlen; i++)
			w = {w[xlen-2:0], next_bit()};
		return w;
	endfunction

	function automatic word_t mstatus_word();
		word_t w;
		w = '0;
		w[1] = exp_sie;
		w[3] = exp_mie;
		w[5] = exp_spie;
		w[7] = exp_mpie;
		w[8] = exp_spp;
		w[12:11] = exp_mpp;
		w[22] = exp_tsr;
		return w;
	endfunction

	function automatic word_t mie_word();
		word_t w;
		w = '0;
		w[5] = exp_stie;
		w[7] = exp_mtie;
		w[9] = exp_seie;
		w[11] = exp_meie;
		return w;
	endfunction

	// privilege rules for one trap, mret or sret
	function automatic void update_model(input cause_t c, input word_t pc, input logic mret,
		input logic sret);
		mode_t old_mode;
		logic  hit;
		old_mode = exp_mode;
		if (mret)
		begin
			if (old_mode == mode_m)
			begin
				exp_mode = exp_mpp;
				exp_mie = exp_mpie;
				exp_mpie = 1'b1;
				exp_mpp = mode_u;
			end
		end
		else if (sret)
		begin
			if (old_mode != mode_u)
			begin
				exp_mode = exp_spp ? mode_s : mode_u;
				exp_sie = exp_spie;
				exp_spie = 1'b1;
				exp_spp = 1'b0;
			end
		end
		else
		begin
			if (c.interrupt)
				hit = (c.code < 12) && exp_mideleg[c.code[3:0]];
			else
				hit = (c.code < 16) && exp_medeleg[c.code[3:0]];
			if (old_mode == mode_m && !hit)
			begin
				exp_mepc = {pc[31:2], 2'b00};
				exp_mcause = c;
				exp_mpie = exp_mie;
				exp_mie = 1'b0;
				exp_mpp = old_mode;
			end
			else if (old_mode != mode_u)
			begin
				exp_mode = mode_s;
				exp_sepc = {pc[31:2], 2'b00};
				exp_scause = c;
				exp_spie = exp_sie;
				exp_sie = 1'b0;
				exp_spp = old_mode[0];
			end
		end
	endfunction

	task automatic write_csr(input csr_addr_t addr, input word_t data);
		@(posedge clk);
		csr_we <= 1'b1;
		csr_address_wb <= addr;
		csr_wb <= data;
		@(posedge clk);
		csr_we <= 1'b0;
	endtask

	task automatic read_check(input csr_addr_t addr, input word_t exp, input string name);
		@(posedge clk);
		csr_address_r <= addr;
		@(negedge clk);
		check_value(name, csr_data, exp);
	endtask

	task automatic take_trap(input cause_t c, input word_t pc, input logic mret, input logic sret);
		word_t target;
		logic  bad_ret;
		@(posedge clk);
		exception_pending <= 1'b1;
		cause <= c;
		pc_exc <= pc;
		m_ret <= mret;
		s_ret <= sret;
		@(negedge clk);
		if (mret)
			target = exp_mepc;
		else if (sret)
			target = exp_sepc;
		else if (exp_mode == mode_m)
			target = exp_mtvec;
		else
			target = exp_stvec;
		bad_ret = (mret && exp_mode != mode_m) || (sret && exp_mode == mode_u);
		check_value("epc", epc, target);
		check_value("illegal_ret", illegal_ret, bad_ret);
		@(posedge clk);
		exception_pending <= 1'b0;
		m_ret <= 1'b0;
		s_ret <= 1'b0;
		update_model(c, pc, mret, sret);	// same edge as the DUT update
		@(negedge clk);
		check_value("current_mode", current_mode, exp_mode);
	endtask

	initial
	begin
		word_t       w;
		cause_t      c;
		logic [63:0] target;
		int          waited;
		nrst = 1'b0;
		csr_we = 1'b0;
		csr_address_wb = '0;
		csr_wb = '0;
		csr_address_r = '0;
		exception_pending = 1'b0;
		cause = '0;
		pc_exc = '0;
		m_ret = 1'b0;
		s_ret = 1'b0;
		m_interrupt = 1'b0;
		s_interrupt = 1'b0;
		lfsr = 16'd98;
		cycles = '0;
		failures = 0;
		exp_mode = mode_m;
		exp_mpp = mode_m;
		exp_tsr = 1'b0;
		{exp_sie, exp_mie, exp_spie, exp_mpie, exp_spp} = '0;
		{exp_stie, exp_mtie, exp_seie, exp_meie} = '0;
		{exp_mtvec, exp_stvec, exp_mepc, exp_sepc} = '0;
		exp_mcause = '0;
		exp_scause = '0;
		exp_medeleg = '0;
		exp_mideleg = '0;

		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		check_value("current_mode", current_mode, mode_m);
		check_value("m_timer", m_timer, 1'b0);
		check_value("s_timer", s_timer, 1'b0);
		check_value("illegal_ret", illegal_ret, 1'b0);
		check_value("epc", epc, 32'h0);

		// plain read/write registers
		w = random_word();
		write_csr(addr_mscratch, w);
		read_check(addr_mscratch, w, "mscratch");
		w = random_word();
		write_csr(addr_sscratch, w);
		read_check(addr_sscratch, w, "sscratch");
		w = random_word();
		write_csr(addr_mtvec, w);
		exp_mtvec = {w[31:2], 2'b00};
		read_check(addr_mtvec, exp_mtvec, "mtvec");
		w = random_word();
		write_csr(addr_stvec, w);
		exp_stvec = {w[31:2], 2'b00};
		read_check(addr_stvec, exp_stvec, "stvec");
		w = random_word();
		write_csr(addr_mepc, w);
		exp_mepc = {w[31:2], 2'b00};
		read_check(addr_mepc, exp_mepc, "mepc");
		w = random_word();
		write_csr(addr_mcause, w);
		exp_mcause = w;
		read_check(addr_mcause, exp_mcause, "mcause");
		w = random_word();
		write_csr(addr_medeleg, w);
		exp_medeleg = w[15:0];
		read_check(addr_medeleg, {16'h0, exp_medeleg}, "medeleg");
		w = random_word();
		write_csr(addr_mie, w);
		{exp_stie, exp_mtie, exp_seie, exp_meie} = {w[5], w[7], w[9], w[11]};
		read_check(addr_mie, mie_word(), "mie");
		w = random_word();
		write_csr(addr_sie, w);
		exp_stie = w[5];	// M bits untouched
		exp_seie = w[9];
		read_check(addr_mie, mie_word(), "mie after sie write");
		@(posedge clk);
		csr_address_r <= addr_time;
		@(negedge clk);
		check_value("time", csr_data, cycles[31:0]);
		read_check(12'h7ff, 32'h0, "unmapped csr");

		// trap kept in M, then mret
		write_csr(addr_medeleg, 32'h0000_0200);
		exp_medeleg = 16'h0200;
		write_csr(addr_mstatus, 32'h0000_1808);
		{exp_sie, exp_mie, exp_spie, exp_mpie, exp_spp} = 5'b01000;
		exp_mpp = mode_m;
		read_check(addr_mstatus, mstatus_word(), "mstatus");
		c.interrupt = 1'b0;
		c.code = exc_ecall_m;
		take_trap(c, random_word(), 1'b0, 1'b0);
		read_check(addr_mcause, exp_mcause, "mcause after trap");
		read_check(addr_mepc, exp_mepc, "mepc after trap");
		read_check(addr_mstatus, mstatus_word(), "mstatus after trap");
		take_trap(c, random_word(), 1'b1, 1'b0);
		read_check(addr_mstatus, mstatus_word(), "mstatus after mret");

		// delegated trap to S, sret, then an mret that S may not issue
		c.code = exc_ecall_s;
		take_trap(c, random_word(), 1'b0, 1'b0);
		read_check(addr_sepc, exp_sepc, "sepc after trap");
		read_check(addr_scause, exp_scause, "scause after trap");
		read_check(addr_sstatus, mstatus_word() & 32'h0000_0122, "sstatus after trap");
		take_trap(c, random_word(), 1'b0, 1'b1);
		take_trap(c, random_word(), 1'b1, 1'b0);
		read_check(addr_mstatus, mstatus_word(), "mstatus after illegal mret");
		@(negedge clk);
		check_value("epc", epc, exp_stvec);

		// interrupt enable gating and tsr
		write_csr(addr_mstatus, 32'h0040_000a);
		{exp_sie, exp_mie, exp_spie, exp_mpie, exp_spp} = 5'b11000;
		exp_mpp = mode_u;
		exp_tsr = 1'b1;
		read_check(addr_mstatus, mstatus_word(), "mstatus with tsr");
		write_csr(addr_mie, 32'h0000_0aa0);
		{exp_stie, exp_mtie, exp_seie, exp_meie} = 4'b1111;
		@(negedge clk);
		check_value("m_tie", m_tie, 1'b1);
		write_csr(addr_mie, 32'h0000_0000);
		{exp_stie, exp_mtie, exp_seie, exp_meie} = 4'b0000;
		@(negedge clk);
		check_value("m_tie", m_tie, 1'b0);

		// compare value a little ahead of the counter
		target = cycles + 64'd40;
		write_csr(addr_mtimecmp, target[31:0]);
		read_check(addr_mtimecmp, target[31:0], "mtimecmp");
		check_value("m_timer", m_timer, 1'b0);
		waited = 0;
		while (!m_timer && waited < 100)
		begin
			@(negedge clk);
			waited++;
		end
		if (!m_timer)
			abort_run("m_timer did not rise after mtime reached mtimecmp");
		check_value("mtime at m_timer rise", cycles, target + 64'd1);

		repeat (2) @(posedge clk);
		if (failures == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
		begin
			$display("TESTBENCH FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

// ==== files.f ====
src/csr_pkg.sv
src/csr_addr_decode.sv
src/csr_trap_ctrl.sv
src/csr_config_regs.sv
src/csr_timer.sv
src/csr_read_result.sv
src/csr_regfile.sv
verification/csr_regfile_tb.sv

// ==== Bender.yml ====
package:
  name: csr_regfile

sources:
  - src/csr_pkg.sv
  - src/csr_addr_decode.sv
  - src/csr_trap_ctrl.sv
  - src/csr_config_regs.sv
  - src/csr_timer.sv
  - src/csr_read_result.sv
  - src/csr_regfile.sv
  - target: simulation
    files:
      - verification/csr_regfile_tb.sv
